/* tb.f */
source/game_pkg.sv
source/player_motion.sv
source/shot_launcher.sv
source/bullet_track.sv
source/ddaver_grid.sv
source/game_state_updater.sv
verif/game_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= game_tb
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
TIMESCALE ?= 1ns/1ps
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= STATUS: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --assert --timescale $(TIMESCALE) \
		-f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(VFLAGS) --timescale $(TIMESCALE) -f $(FILELIST) \
		--top-module $(TOP) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

/* verif/game_tb.sv */
`timescale 1ns/1ps

module game_tb import game_pkg::*; ();

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 16;
    // Rough cycle cost of reset and of each test
    localparam int TEST_CYCLES  = RESET_CYCLES + 40 + 70 + 50 + 22 * 16 + 30;
    localparam int WATCHDOG_NS  = 2 * TEST_CYCLES * CLK_PERIOD;
    localparam int CELLS        = NUM_ROWS * NUM_COLS;

    logic                                  blockieee_clock;
    logic                                  rst;
    logic                                  step;
    logic [7:0]                            stick_y;
    logic                                  z;
    logic                                  c;
    logic                                  spawn;
    logic [ROW_W-1:0]                      spawn_row;
    logic [COL_W-1:0]                      spawn_col;
    ddaver_color_t                         spawn_color;
    logic [ROW_W-1:0]                      player_row;
    bullet_color_t [NUM_BULLETS-1:0]       bullet_color;
    logic [NUM_BULLETS-1:0][ROW_W-1:0]     bullet_row;
    logic [NUM_BULLETS-1:0][COL_W-1:0]     bullet_col;
    ddaver_color_t [NUM_ROWS*NUM_COLS-1:0] ddaver_colors;

    // Scoreboard state
    ddaver_color_t model [CELLS];
    int            exp_row;
    int            errors;
    int            checks;

    game_state_updater dut (
        .blockieee_clock (blockieee_clock),
        .rst             (rst),
        .step            (step),
        .stick_y         (stick_y),
        .z               (z),
        .c               (c),
        .spawn           (spawn),
        .spawn_row       (spawn_row),
        .spawn_col       (spawn_col),
        .spawn_color     (spawn_color),
        .player_row      (player_row),
        .bullet_color    (bullet_color),
        .bullet_row      (bullet_row),
        .bullet_col      (bullet_col),
        .ddaver_colors   (ddaver_colors)
    );

    always #(CLK_PERIOD / 2) blockieee_clock = ~blockieee_clock;

    //////////////////////////////////////////////////////////////////////
    // Reference rule and checking helpers
    //////////////////////////////////////////////////////////////////////

    // Mixed colour hit by one primary keeps the other one
    function automatic ddaver_color_t expected_color(ddaver_color_t cur, bullet_color_t b);
        ddaver_color_t shot;
        ddaver_color_t p1;
        ddaver_color_t p2;
        ddaver_color_t res;
        case (b)
            BB_BLUE:  shot = BLUE;
            BB_RED:   shot = RED;
            BB_GREEN: shot = GREEN;
            default:  shot = DDNE;
        endcase
        case (cur)
            PURPLE: begin
                p1 = BLUE;
                p2 = RED;
            end
            ORANGE: begin
                p1 = RED;
                p2 = GREEN;
            end
            YELLOW: begin
                p1 = BLUE;
                p2 = GREEN;
            end
            default: begin
                p1 = DDNE;
                p2 = DDNE;
            end
        endcase
        res = cur;
        if (shot != DDNE) begin
            if (cur == shot) begin
                res = DDNE;
            end else if (shot == p1) begin
                res = p2;
            end else if (shot == p2) begin
                res = p1;
            end
        end
        return res;
    endfunction

    task automatic check_val(input string name, input int got, input int exp);
        checks++;
        assert (got == exp) else begin
            errors++;
            $display("FAIL t=%0t %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    function automatic int live_count();
        int n;
        n = 0;
        for (int i = 0; i < NUM_BULLETS; i++) begin
            if (bullet_color[i] != BB_NONE) begin
                n++;
            end
        end
        return n;
    endfunction

    task automatic check_grid();
        for (int k = 0; k < CELLS; k++) begin
            check_val($sformatf("ddaver_colors[%0d]", k), int'(ddaver_colors[k]),
                int'(model[k]));
        end
    endtask

    task automatic check_slot(input int i, input bullet_color_t colr, input int row,
                              input int col);
        check_val($sformatf("bullet_color[%0d]", i), int'(bullet_color[i]), int'(colr));
        if (colr != BB_NONE) begin
            check_val($sformatf("bullet_row[%0d]", i), int'(bullet_row[i]), row);
            check_val($sformatf("bullet_col[%0d]", i), int'(bullet_col[i]), col);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Stimulus helpers
    //////////////////////////////////////////////////////////////////////

    // One game step that returns at the falling edge after the update
    task automatic game_step();
        @(posedge blockieee_clock);
        // Saturating row rule on the stick seen at the step edge
        if (int'(stick_y) > STICK_CENTER + SENSITIVITY && exp_row > 0) begin
            exp_row--;
        end else if (int'(stick_y) < STICK_CENTER - SENSITIVITY && exp_row < NUM_ROWS - 1) begin
            exp_row++;
        end
        step <= 1'b1;
        @(posedge blockieee_clock);
        step <= 1'b0;
        @(negedge blockieee_clock);
    endtask

    task automatic set_stick(input logic [7:0] v);
        @(posedge blockieee_clock);
        stick_y <= v;
    endtask

    // Button pattern for a bullet colour
    // Both buttons together give green
    task automatic fire(input bullet_color_t b);
        @(posedge blockieee_clock);
        z <= (b == BB_BLUE || b == BB_GREEN);
        c <= (b == BB_RED || b == BB_GREEN);
        @(posedge blockieee_clock);
        z <= 1'b0;
        c <= 1'b0;
    endtask

    task automatic spawn_cell(input int r, input int col, input ddaver_color_t colr);
        @(posedge blockieee_clock);
        spawn       <= 1'b1;
        spawn_row   <= ROW_W'(r);
        spawn_col   <= COL_W'(col);
        spawn_color <= colr;
        @(posedge blockieee_clock);
        spawn <= 1'b0;
        model[r * NUM_COLS + col] = colr;
    endtask

    //////////////////////////////////////////////////////////////////////
    // Directed tests
    //////////////////////////////////////////////////////////////////////

    task automatic test_reset();
        check_val("player_row", int'(player_row), START_ROW);
        for (int i = 0; i < NUM_BULLETS; i++) begin
            check_slot(i, BB_NONE, 0, 0);
        end
        check_grid();
    endtask

    task automatic motion_steps(input logic [7:0] v, input int n);
        set_stick(v);
        repeat (n) begin
            game_step();
            check_val("player_row", int'(player_row), exp_row);
        end
    endtask

    task automatic test_motion();
        // Up into the top edge, then both dead band edges, then down to the bottom
        motion_steps(8'd200, 3);
        motion_steps(8'd148, 2);
        motion_steps(8'd108, 1);
        motion_steps(8'd40, 6);
        set_stick(8'd128);
    endtask

    task automatic test_flight();
        bullet_color_t shots [3];
        int launch_row;
        shots[0] = BB_BLUE;
        shots[1] = BB_RED;
        shots[2] = BB_GREEN;
        for (int k = 0; k < 3; k++) begin
            fire(shots[k]);
            launch_row = exp_row;
            // Second shot launches on a step that also moves the player
            if (k == 1) begin
                set_stick(8'd220);
            end
            game_step();
            if (k == 1) begin
                set_stick(8'd128);
            end
            check_val("player_row", int'(player_row), exp_row);
            check_slot(0, shots[k], launch_row, 0);
            check_val("live bullets", live_count(), 1);
            for (int col = 1; col < NUM_COLS; col++) begin
                game_step();
                check_slot(0, shots[k], launch_row, col);
            end
            game_step();
            check_val("live bullets", live_count(), 0);
        end
    endtask

    task automatic test_slot_limit();
        fire(BB_RED);
        game_step();
        fire(BB_GREEN);
        game_step();
        fire(BB_BLUE);
        game_step();
        check_val("live bullets", live_count(), 3);
        // Fourth shot waits until slot 0 runs off the grid
        fire(BB_RED);
        for (int s = 4; s <= 7; s++) begin
            game_step();
            check_val("live bullets", live_count(), 3);
            check_val("bullet_col[2]", int'(bullet_col[2]), s - 3);
        end
        check_slot(0, BB_RED, exp_row, 0);
        repeat (7) begin
            game_step();
        end
        check_val("live bullets", live_count(), 0);
    endtask

    task automatic hit_cell(input int r, input ddaver_color_t e, input bullet_color_t b);
        int idx;
        idx = r * NUM_COLS + 2;
        spawn_cell(r, 2, e);
        fire(b);
        // Columns 0, 1, 2 and then the collision step
        repeat (4) begin
            game_step();
        end
        model[idx] = expected_color(model[idx], b);
        @(negedge blockieee_clock);
        check_grid();
        check_val("live bullets", live_count(), 0);
    endtask

    task automatic test_colour_rule();
        int r;
        int e;
        r = exp_row;
        for (int k = 1; k <= 6; k++) begin
            for (int b = 1; b <= 3; b++) begin
                hit_cell(r, ddaver_color_t'(3'(k)), bullet_color_t'(2'(b)));
            end
        end
        // A few extra pairings with random enemy colours
        for (int k = 0; k < 4; k++) begin
            e = 1 + int'($urandom % 6);
            hit_cell(r, ddaver_color_t'(3'(e)), bullet_color_t'(2'(1 + k % 3)));
        end
        spawn_cell(r, 2, DDNE);
    endtask

    task automatic test_spawn_priority();
        int r;
        r = exp_row;
        spawn_cell(r, 4, BLUE);
        fire(BB_BLUE);
        repeat (5) begin
            game_step();
        end
        // Spawn lands on the edge that applies the collision hit
        @(posedge blockieee_clock);
        step <= 1'b1;
        @(posedge blockieee_clock);
        step        <= 1'b0;
        spawn       <= 1'b1;
        spawn_row   <= ROW_W'(r);
        spawn_col   <= COL_W'(4);
        spawn_color <= ORANGE;
        @(posedge blockieee_clock);
        spawn <= 1'b0;
        model[r * NUM_COLS + 4] = ORANGE;
        @(negedge blockieee_clock);
        check_grid();
        check_val("live bullets", live_count(), 0);
        spawn_cell(r, 4, DDNE);
        @(negedge blockieee_clock);
        check_grid();
    endtask

    //////////////////////////////////////////////////////////////////////
    // Main sequence and watchdog
    //////////////////////////////////////////////////////////////////////
    initial begin
        void'($urandom(52));
        blockieee_clock = 1'b0;
        rst             = 1'b1;
        step            = 1'b0;
        stick_y         = 8'd128;
        z               = 1'b0;
        c               = 1'b0;
        spawn           = 1'b0;
        spawn_row       = '0;
        spawn_col       = '0;
        spawn_color     = DDNE;
        errors          = 0;
        checks          = 0;
        exp_row         = START_ROW;
        for (int k = 0; k < CELLS; k++) begin
            model[k] = DDNE;
        end
        repeat (RESET_CYCLES) @(posedge blockieee_clock);
        rst <= 1'b0;
        @(negedge blockieee_clock);
        test_reset();
        test_motion();
        test_flight();
        test_slot_limit();
        test_colour_rule();
        test_spawn_priority();
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: tests did not finish within %0d ns", WATCHDOG_NS);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

/* source/game_state_updater.sv */
`timescale 1ns/1ps

module game_state_updater import game_pkg::*; (
    input  logic                                  blockieee_clock,
    input  logic                                  rst,
    input  logic                                  step,
    input  logic [7:0]                            stick_y,
    input  logic                                  z,
    input  logic                                  c,
    input  logic                                  spawn,
    input  logic [ROW_W-1:0]                      spawn_row,
    input  logic [COL_W-1:0]                      spawn_col,
    input  ddaver_color_t                         spawn_color,
    output logic [ROW_W-1:0]                      player_row,
    output bullet_color_t [NUM_BULLETS-1:0]       bullet_color,
    output logic [NUM_BULLETS-1:0][ROW_W-1:0]     bullet_row,
    output logic [NUM_BULLETS-1:0][COL_W-1:0]     bullet_col,
    output ddaver_color_t [NUM_ROWS*NUM_COLS-1:0] ddaver_colors
);

    // Launcher to track
    bullet_color_t shot_color;
    logic          shot_taken;

    // Track to grid, and occupancy back
    logic [NUM_BULLETS-1:0]            hit_valid;
    logic [NUM_BULLETS-1:0][ROW_W-1:0] hit_row;
    logic [NUM_BULLETS-1:0][COL_W-1:0] hit_col;
    bullet_color_t [NUM_BULLETS-1:0]   hit_color;
    logic [NUM_ROWS*NUM_COLS-1:0]      occupied;

    player_motion u_player_motion (
        .blockieee_clock (blockieee_clock),
        .rst             (rst),
        .step            (step),
        .stick_y         (stick_y),
        .player_row      (player_row)
    );

    shot_launcher u_shot_launcher (
        .blockieee_clock (blockieee_clock),
        .rst             (rst),
        .z               (z),
        .c               (c),
        .shot_taken      (shot_taken),
        .shot_color      (shot_color)
    );

    bullet_track u_bullet_track (
        .blockieee_clock (blockieee_clock),
        .rst             (rst),
        .step            (step),
        .player_row      (player_row),
        .shot_color      (shot_color),
        .occupied        (occupied),
        .shot_taken      (shot_taken),
        .bullet_color    (bullet_color),
        .bullet_row      (bullet_row),
        .bullet_col      (bullet_col),
        .hit_valid       (hit_valid),
        .hit_row         (hit_row),
        .hit_col         (hit_col),
        .hit_color       (hit_color)
    );

    ddaver_grid u_ddaver_grid (
        .blockieee_clock (blockieee_clock),
        .rst             (rst),
        .spawn           (spawn),
        .spawn_row       (spawn_row),
        .spawn_col       (spawn_col),
        .spawn_color     (spawn_color),
        .hit_valid       (hit_valid),
        .hit_row         (hit_row),
        .hit_col         (hit_col),
        .hit_color       (hit_color),
        .ddaver_colors   (ddaver_colors),
        .occupied        (occupied)
    );

endmodule

/* source/ddaver_grid.sv */
`timescale 1ns/1ps

module ddaver_grid import game_pkg::*; (
    input  logic                                     blockieee_clock,
    input  logic                                     rst,
    input  logic                                     spawn,
    input  logic [ROW_W-1:0]                         spawn_row,
    input  logic [COL_W-1:0]                         spawn_col,
    input  ddaver_color_t                            spawn_color,
    input  logic [NUM_BULLETS-1:0]                   hit_valid,
    input  logic [NUM_BULLETS-1:0][ROW_W-1:0]        hit_row,
    input  logic [NUM_BULLETS-1:0][COL_W-1:0]        hit_col,
    input  bullet_color_t [NUM_BULLETS-1:0]          hit_color,
    output ddaver_color_t [NUM_ROWS*NUM_COLS-1:0]    ddaver_colors,
    output logic [NUM_ROWS*NUM_COLS-1:0]             occupied
);

    ddaver_color_t [NUM_ROWS*NUM_COLS-1:0] nxt_cells;
    logic [NUM_ROWS*NUM_COLS-1:0]          claimed;

    //////////////////////////////////////////////////////////////////////
    // Next state of all thirty cells
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        int idx;
        nxt_cells = ddaver_colors;
        claimed   = '0;
        // Lowest slot first, later slots on the same cell skipped
        for (int i = 0; i < NUM_BULLETS; i++) begin
            idx = int'(hit_row[i]) * NUM_COLS + int'(hit_col[i]);
            if (hit_valid[i] && !claimed[idx]) begin
                claimed[idx]   = 1'b1;
                nxt_cells[idx] = next_color(ddaver_colors[idx], hit_color[i]);
            end
        end
        // Spawn overrides a hit on the same cell
        if (spawn) begin
            idx            = int'(spawn_row) * NUM_COLS + int'(spawn_col);
            nxt_cells[idx] = spawn_color;
        end
    end

    always_ff @(posedge blockieee_clock) begin
        if (rst) begin
            for (int k = 0; k < NUM_ROWS * NUM_COLS; k++) begin
                ddaver_colors[k] <= DDNE;
            end
        end else begin
            ddaver_colors <= nxt_cells;
        end
    end

    // Occupancy map for the bullet track
    always_comb begin
        for (int k = 0; k < NUM_ROWS * NUM_COLS; k++) begin
            occupied[k] = (ddaver_colors[k] != DDNE);
        end
    end

    // Spawner must stay inside the playfield
    spawn_in_grid_a: assert property (@(posedge blockieee_clock) disable iff (rst)
        spawn |-> (spawn_row < ROW_W'(NUM_ROWS)) && (spawn_col < COL_W'(NUM_COLS)))
        else $error("spawn at row %0d col %0d off the grid", spawn_row, spawn_col);

endmodule

/* source/bullet_track.sv */
`timescale 1ns/1ps

module bullet_track import game_pkg::*; (
    input  logic                                 blockieee_clock,
    input  logic                                 rst,
    input  logic                                 step,
    input  logic [ROW_W-1:0]                     player_row,
    input  bullet_color_t                        shot_color,
    input  logic [NUM_ROWS*NUM_COLS-1:0]         occupied,
    output logic                                 shot_taken,
    output bullet_color_t [NUM_BULLETS-1:0]      bullet_color,
    output logic [NUM_BULLETS-1:0][ROW_W-1:0]    bullet_row,
    output logic [NUM_BULLETS-1:0][COL_W-1:0]    bullet_col,
    output logic [NUM_BULLETS-1:0]               hit_valid,
    output logic [NUM_BULLETS-1:0][ROW_W-1:0]    hit_row,
    output logic [NUM_BULLETS-1:0][COL_W-1:0]    hit_col,
    output bullet_color_t [NUM_BULLETS-1:0]      hit_color
);

    bullet_color_t [NUM_BULLETS-1:0]   nxt_color;
    logic [NUM_BULLETS-1:0][ROW_W-1:0] nxt_row;
    logic [NUM_BULLETS-1:0][COL_W-1:0] nxt_col;
    logic [NUM_BULLETS-1:0]            slot_hit;
    logic                              load_done;

    //////////////////////////////////////////////////////////////////////
    // Slot update for one step
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        nxt_color = bullet_color;
        nxt_row   = bullet_row;
        nxt_col   = bullet_col;
        slot_hit  = '0;
        load_done = 1'b0;
        // Collide, retire or advance each live bullet
        for (int i = 0; i < NUM_BULLETS; i++) begin
            if (bullet_color[i] != BB_NONE) begin
                if (occupied[int'(bullet_row[i]) * NUM_COLS + int'(bullet_col[i])]) begin
                    slot_hit[i]  = 1'b1;
                    nxt_color[i] = BB_NONE;
                end else if (bullet_col[i] == COL_W'(NUM_COLS - 1)) begin
                    // Ran off the right edge
                    nxt_color[i] = BB_NONE;
                end else begin
                    nxt_col[i] = bullet_col[i] + COL_W'(1);
                end
            end
        end
        // Pending shot goes to the lowest free slot
        for (int i = 0; i < NUM_BULLETS; i++) begin
            if (!load_done && shot_color != BB_NONE && nxt_color[i] == BB_NONE) begin
                nxt_color[i] = shot_color;
                nxt_row[i]   = player_row;
                nxt_col[i]   = '0;
                load_done    = 1'b1;
            end
        end
    end

    // Same edge as the load, so the launcher clears in step
    assign shot_taken = step && load_done;

    always_ff @(posedge blockieee_clock) begin
        if (rst) begin
            for (int i = 0; i < NUM_BULLETS; i++) begin
                bullet_color[i] <= BB_NONE;
            end
            hit_valid <= '0;
        end else if (step) begin
            bullet_color <= nxt_color;
            hit_valid    <= slot_hit;
        end else begin
            // Hit report lasts one cycle
            hit_valid <= '0;
        end
    end

    // Position and hit payload
    always_ff @(posedge blockieee_clock) begin
        if (step) begin
            bullet_row <= nxt_row;
            bullet_col <= nxt_col;
            hit_row    <= bullet_row;
            hit_col    <= bullet_col;
            hit_color  <= bullet_color;
        end
    end

    for (genvar i = 0; i < NUM_BULLETS; i++) begin : g_slot_checks
        col_in_range_a: assert property (@(posedge blockieee_clock) disable iff (rst)
            (bullet_color[i] != BB_NONE) |-> (bullet_col[i] < COL_W'(NUM_COLS)))
            else $error("slot %0d column %0d off the grid", i, bullet_col[i]);
        // A hit always carries a real colour
        hit_has_color_a: assert property (@(posedge blockieee_clock) disable iff (rst)
            hit_valid[i] |-> hit_color[i] != BB_NONE)
            else $error("slot %0d hit without a colour", i);
    end

endmodule

/* source/shot_launcher.sv */
`timescale 1ns/1ps

module shot_launcher import game_pkg::*; (
    input  logic          blockieee_clock,
    input  logic          rst,
    input  logic          z,
    input  logic          c,
    input  logic          shot_taken,
    output bullet_color_t shot_color
);

    logic z_q;
    logic c_q;
    logic press;
    bullet_color_t btn_color;

    // Rising edge on either button
    assign press = (z && !z_q) || (c && !c_q);

    // Button combination to bullet colour
    always_comb begin
        if (z && c) begin
            btn_color = BB_GREEN;
        end else if (z) begin
            btn_color = BB_BLUE;
        end else begin
            btn_color = BB_RED;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Pending shot, held until the bullet track takes it
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge blockieee_clock) begin
        if (rst) begin
            z_q        <= 1'b0;
            c_q        <= 1'b0;
            shot_color <= BB_NONE;
        end else begin
            z_q <= z;
            c_q <= c;
            if (shot_taken) begin
                shot_color <= BB_NONE;
            end else if (press && shot_color == BB_NONE) begin
                // Presses while pending are dropped
                shot_color <= btn_color;
            end
        end
    end

    // Track only takes a shot that is pending
    taken_when_pending_a: assert property (@(posedge blockieee_clock) disable iff (rst)
        shot_taken |-> shot_color != BB_NONE)
        else $error("shot_taken with no pending shot");

endmodule

/* source/player_motion.sv */
`timescale 1ns/1ps

module player_motion import game_pkg::*; (
    input  logic             blockieee_clock,
    input  logic             rst,
    input  logic             step,
    input  logic [7:0]       stick_y,
    output logic [ROW_W-1:0] player_row
);

    // Stick direction after the dead band
    typedef enum logic [1:0] {
        STEADY,
        UP,
        DOWN
    } stick_dir_t;

    stick_dir_t dir;

    // Classify the stick against the centre
    always_comb begin
        if (int'(stick_y) > STICK_CENTER + SENSITIVITY) begin
            dir = UP;
        end else if (int'(stick_y) < STICK_CENTER - SENSITIVITY) begin
            dir = DOWN;
        end else begin
            dir = STEADY;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Row register, one row per step at most
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge blockieee_clock) begin
        if (rst) begin
            player_row <= ROW_W'(START_ROW);
        end else if (step) begin
            case (dir)
                // Row 0 is the top edge
                UP: begin
                    if (player_row != '0) begin
                        player_row <= player_row - ROW_W'(1);
                    end
                end
                DOWN: begin
                    if (player_row != ROW_W'(NUM_ROWS - 1)) begin
                        player_row <= player_row + ROW_W'(1);
                    end
                end
                default: player_row <= player_row;
            endcase
        end
    end

    // Saturation keeps the row on the grid
    row_in_range_a: assert property (@(posedge blockieee_clock) disable iff (rst)
        player_row < ROW_W'(NUM_ROWS))
        else $error("player_row %0d left the grid", player_row);

endmodule

/* source/game_pkg.sv */
package game_pkg;

    //////////////////////////////////////////////////////////////////////
    // Playfield geometry
    //////////////////////////////////////////////////////////////////////
    localparam int NUM_ROWS    = 5;
    localparam int NUM_COLS    = 6;
    localparam int NUM_BULLETS = 3;
    localparam int ROW_W       = 3;
    localparam int COL_W       = 3;
    localparam int START_ROW   = 2;

    // Nunchuk stick calibration
    localparam int STICK_CENTER = 128;
    localparam int SENSITIVITY  = 20;

    // Enemy cell state, DDNE means the cell is empty
    typedef enum logic [2:0] {
        DDNE   = 3'd0,
        PURPLE = 3'd1,
        ORANGE = 3'd2,
        YELLOW = 3'd3,
        BLUE   = 3'd4,
        RED    = 3'd5,
        GREEN  = 3'd6
    } ddaver_color_t;

    // Bullet slot state, BB_NONE means no bullet
    typedef enum logic [1:0] {
        BB_NONE  = 2'd0,
        BB_BLUE  = 2'd1,
        BB_RED   = 2'd2,
        BB_GREEN = 2'd3
    } bullet_color_t;

    //////////////////////////////////////////////////////////////////////
    // Colour change on a hit
    //////////////////////////////////////////////////////////////////////
    function automatic ddaver_color_t next_color(ddaver_color_t cur, bullet_color_t hit);
        ddaver_color_t res;
        res = cur;
        case (cur)
            // Mixed colours split into a primary
            PURPLE: begin
                case (hit)
                    BB_BLUE: res = RED;
                    BB_RED:  res = BLUE;
                    default: res = cur;
                endcase
            end
            ORANGE: begin
                case (hit)
                    BB_GREEN: res = RED;
                    BB_RED:   res = GREEN;
                    default:  res = cur;
                endcase
            end
            YELLOW: begin
                case (hit)
                    BB_BLUE:  res = GREEN;
                    BB_GREEN: res = BLUE;
                    default:  res = cur;
                endcase
            end
            // Primary hit by its own colour dies
            BLUE: begin
                if (hit == BB_BLUE) begin
                    res = DDNE;
                end
            end
            RED: begin
                if (hit == BB_RED) begin
                    res = DDNE;
                end
            end
            GREEN: begin
                if (hit == BB_GREEN) begin
                    res = DDNE;
                end
            end
            default: res = cur;
        endcase
        return res;
    endfunction

endpackage
